/* hdl/chan_pkg.sv */
//------------------------------------------------------------
// Channel types of the shared FIFO
// Channel id and per-channel item count
//------------------------------------------------------------
`include "fifo_cfg.svh"

package chan_pkg;

  // Widths derived from the build macros
  localparam int CHAN_W  = $clog2(`FIFO_CHANNELS);
  localparam int COUNT_W = $clog2(`FIFO_DEPTH + 1);

  // Channel id, also the upper address field
  typedef logic [CHAN_W-1:0] chan_t;

  // Item count, 0 up to FIFO_DEPTH inclusive
  typedef logic [COUNT_W-1:0] count_t;

endpackage

/* hdl/dual_fifo_top.sv */
//------------------------------------------------------------
// Two-channel FIFO with shared storage
// Per-channel push/pop control, one arbitrated write port
//------------------------------------------------------------
`timescale 1ns/1ns
`include "fifo_cfg.svh"

module dual_fifo_top (
  input  logic                      clk,
  input  logic                      rst_n,

  // Push side, per channel
  input  logic [`FIFO_CHANNELS-1:0] push_valid,
  output logic [`FIFO_CHANNELS-1:0] push_ready,
  input  ram_pkg::data_t            push_data [`FIFO_CHANNELS],

  // Pop side, per channel
  input  logic [`FIFO_CHANNELS-1:0] pop_ready,
  output logic [`FIFO_CHANNELS-1:0] pop_valid,
  output ram_pkg::data_t            pop_data [`FIFO_CHANNELS],

  // Status flags, per channel
  output chan_pkg::count_t          items [`FIFO_CHANNELS],
  output logic [`FIFO_CHANNELS-1:0] empty
);
  import ram_pkg::*;
  import chan_pkg::*;

  //------------------------------------------------------------
  // Interconnect
  //------------------------------------------------------------
  // Push controller to arbiter
  ram_wr_if    wr_port [`FIFO_CHANNELS] ();
  // Push to pop controller of the same channel
  fifo_ctrl_if ctrl    [`FIFO_CHANNELS] ();

  // Shared write port
  logic      wr_en;
  ram_addr_u wr_addr;
  data_t     wr_data;

  // Per-channel read ports
  ram_addr_u rd_addr [`FIFO_CHANNELS];
  data_t     rd_data [`FIFO_CHANNELS];

  //------------------------------------------------------------
  // Shared blocks
  //------------------------------------------------------------
  wr_arbiter u_arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_port (wr_port),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  fifo_ram u_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  //------------------------------------------------------------
  // Channel controllers
  //------------------------------------------------------------
  for (genvar g = 0; g < `FIFO_CHANNELS; g++) begin : g_chan
    fifo_push_ctrl #(
      .chan_id (chan_t'(g))
    ) u_push (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (push_valid[g]),
      .push_ready (push_ready[g]),
      .push_data  (push_data[g]),
      .wr         (wr_port[g]),
      .ctrl       (ctrl[g])
    );

    fifo_pop_ctrl #(
      .chan_id (chan_t'(g))
    ) u_pop (
      .clk       (clk),
      .rst_n     (rst_n),
      .pop_ready (pop_ready[g]),
      .pop_valid (pop_valid[g]),
      .pop_data  (pop_data[g]),
      .items     (items[g]),
      .empty     (empty[g]),
      .rd_addr   (rd_addr[g]),
      .rd_data   (rd_data[g]),
      .ctrl      (ctrl[g])
    );
  end

endmodule

/* hdl/fifo_cfg.svh */
//------------------------------------------------------------
// Build-time sizing of the two-channel shared FIFO
// Channel count, entries per channel and data width
//------------------------------------------------------------
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// Number of independent channels
`define FIFO_CHANNELS 2

// Entries per channel region in the shared RAM
`define FIFO_DEPTH 4

// Bits per stored word
`define FIFO_WIDTH 8

`endif

/* hdl/fifo_ifs.sv */
//------------------------------------------------------------
// Internal buses of the shared FIFO
// RAM write request bus and push/pop control bus
//------------------------------------------------------------
`timescale 1ns/1ns

//------------------------------------------------------------
// Write request from one push controller to the arbiter
//------------------------------------------------------------
interface ram_wr_if;
  import ram_pkg::*;

  // Write fires when req and grant are both high
  logic      req;
  logic      grant;
  ram_addr_u addr;
  data_t     data;

  modport requester (output req, output addr, output data, input grant);

  // Grant only ever follows a req
  modport arbiter (input req, input addr, input data, output grant);
endinterface

//------------------------------------------------------------
// Push to pop handshakes of one channel
//------------------------------------------------------------
interface fifo_ctrl_if;
  import ram_pkg::*;

  // Entry count events
  logic  ram_push;
  logic  ram_pop;

  // Bypass path, used only while the channel is empty
  logic  bypass_valid;
  logic  bypass_ready;
  data_t bypass_data;

  modport push (
    output ram_push, output bypass_valid, output bypass_data,
    input  ram_pop,  input  bypass_ready
  );

  modport pop (
    input  ram_push, input  bypass_valid, input bypass_data,
    output ram_pop,  output bypass_ready
  );
endinterface

/* hdl/fifo_pop_ctrl.sv */
//------------------------------------------------------------
// Pop controller of one FIFO channel
// Zero-latency RAM read, bypass mux, items and empty flags
//------------------------------------------------------------
`timescale 1ns/1ns

module fifo_pop_ctrl #(
  parameter chan_pkg::chan_t chan_id = '0
) (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               pop_ready,
  output logic               pop_valid,
  output ram_pkg::data_t     pop_data,

  // Status flags
  output chan_pkg::count_t   items,
  output logic               empty,

  // Combinational read port
  output ram_pkg::ram_addr_u rd_addr,
  input  ram_pkg::data_t     rd_data,

  // Handshakes with the push side
  fifo_ctrl_if.pop           ctrl
);
  import ram_pkg::*;
  import chan_pkg::*;

  logic   pop;
  // Head slot of this channel
  slot_t  rd_slot;
  count_t items_next;
  logic   empty_next;

  //------------------------------------------------------------
  // Datapath
  //------------------------------------------------------------
  assign pop = pop_valid && pop_ready;

  // Bypass only when empty and the consumer is ready
  assign ctrl.bypass_ready = empty && pop_ready;
  assign pop_valid         = ctrl.bypass_valid || !empty;
  assign pop_data          = ctrl.bypass_valid ? ctrl.bypass_data : rd_data;

  // A bypassed word never touches the RAM
  assign ctrl.ram_pop = pop && !ctrl.bypass_valid;

  // Read address is the head, data returns same cycle
  always_comb begin
    rd_addr.cs.chan = chan_id;
    rd_addr.cs.slot = rd_slot;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_slot <= '0;
    end else if (ctrl.ram_pop) begin
      rd_slot <= slot_incr(rd_slot);
    end
  end

  //------------------------------------------------------------
  // Status flags
  //------------------------------------------------------------
  always_comb begin
    items_next = items;
    if (ctrl.ram_push && !ctrl.ram_pop) begin
      items_next = items + 1'b1;
    end else if (!ctrl.ram_push && ctrl.ram_pop) begin
      items_next = items - 1'b1;
    end
  end

  assign empty_next = (items_next == '0);

  // Registered only on a count event
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
      empty <= 1'b1;
    end else if (ctrl.ram_push || ctrl.ram_pop) begin
      items <= items_next;
      empty <= empty_next;
    end
  end

endmodule

/* hdl/fifo_push_ctrl.sv */
//------------------------------------------------------------
// Push controller of one FIFO channel
// Tracks stored slots, steers to bypass or RAM write request
//------------------------------------------------------------
`timescale 1ns/1ns
`include "fifo_cfg.svh"

module fifo_push_ctrl #(
  parameter chan_pkg::chan_t chan_id = '0
) (
  input  logic           clk,
  input  logic           rst_n,

  input  logic           push_valid,
  output logic           push_ready,
  input  ram_pkg::data_t push_data,

  // Shared write port request
  ram_wr_if.requester    wr,

  // Handshakes with the pop side
  fifo_ctrl_if.push      ctrl
);
  import ram_pkg::*;
  import chan_pkg::*;

  //------------------------------------------------------------
  // State
  //------------------------------------------------------------
  // Entries held in RAM for this channel
  count_t    used;
  // Next slot to write
  slot_t     wr_slot;
  logic      full;
  ram_addr_u wr_addr;

  assign full = (used == count_t'(`FIFO_DEPTH));

  //------------------------------------------------------------
  // Bypass steering
  //------------------------------------------------------------
  // Offer the word to the pop side only when it can take it now
  assign ctrl.bypass_valid = push_valid && ctrl.bypass_ready;
  assign ctrl.bypass_data  = push_data;

  //------------------------------------------------------------
  // RAM write request
  //------------------------------------------------------------
  // Bypass taken means no RAM write
  assign wr.req = push_valid && !full && !ctrl.bypass_ready;

  // Channel region plus slot
  always_comb begin
    wr_addr.cs.chan = chan_id;
    wr_addr.cs.slot = wr_slot;
  end

  assign wr.addr = wr_addr;
  assign wr.data = push_data;

  // Granted request is the write itself
  assign ctrl.ram_push = wr.req && wr.grant;

  // Accept on bypass or on a granted write
  assign push_ready = ctrl.bypass_ready || wr.grant;

  //------------------------------------------------------------
  // Slot tracking
  //------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      used    <= '0;
      wr_slot <= '0;
    end else begin
      if (ctrl.ram_push) begin
        wr_slot <= slot_incr(wr_slot);
      end
      // Simultaneous push and pop leaves the count alone
      if (ctrl.ram_push && !ctrl.ram_pop) begin
        used <= used + 1'b1;
      end else if (!ctrl.ram_push && ctrl.ram_pop) begin
        used <= used - 1'b1;
      end
    end
  end

endmodule

/* hdl/fifo_ram.sv */
//------------------------------------------------------------
// Shared storage of all FIFO channels
// One synchronous write port, one async read port per channel
//------------------------------------------------------------
`timescale 1ns/1ns
`include "fifo_cfg.svh"

module fifo_ram (
  input  logic               clk,

  // Write port from the arbiter
  input  logic               wr_en,
  input  ram_pkg::ram_addr_u wr_addr,
  input  ram_pkg::data_t     wr_data,

  // Read ports, one per channel
  input  ram_pkg::ram_addr_u rd_addr [`FIFO_CHANNELS],
  output ram_pkg::data_t     rd_data [`FIFO_CHANNELS]
);
  import ram_pkg::*;

  // Channel regions laid out back to back
  data_t mem [`FIFO_CHANNELS * `FIFO_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr.flat] <= wr_data;
    end
  end

  // Zero-latency reads
  for (genvar g = 0; g < `FIFO_CHANNELS; g++) begin : g_rd
    assign rd_data[g] = mem[rd_addr[g].flat];
  end

endmodule

/* hdl/ram_pkg.sv */
//------------------------------------------------------------
// Storage types of the shared FIFO RAM
// Data word, slot index and the two-view address union
//------------------------------------------------------------
`include "fifo_cfg.svh"

package ram_pkg;

  // Slot field width, address is chan:slot
  localparam int SLOT_W = $clog2(`FIFO_DEPTH);
  localparam int ADDR_W = $bits(chan_pkg::chan_t) + SLOT_W;

  // One stored word
  typedef logic [`FIFO_WIDTH-1:0] data_t;

  // Slot within one channel region
  typedef logic [SLOT_W-1:0] slot_t;

  // Flat view indexes the array, cs view is built by the controllers
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      chan_pkg::chan_t chan;
      slot_t           slot;
    } cs;
  } ram_addr_u;

  // Next slot, wraps at the region end
  function automatic slot_t slot_incr(slot_t s);
    slot_t nxt;
    if (s == slot_t'(`FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = s + 1'b1;
    end
    return nxt;
  endfunction

endpackage

/* hdl/wr_arbiter.sv */
//------------------------------------------------------------
// Round-robin arbiter for the shared RAM write port
// One grant per cycle, muxes the winner onto the RAM
//------------------------------------------------------------
`timescale 1ns/1ns
`include "fifo_cfg.svh"

module wr_arbiter (
  input  logic               clk,
  input  logic               rst_n,

  // One request bus per channel
  ram_wr_if.arbiter          req_port [`FIFO_CHANNELS],

  // RAM write port
  output logic               wr_en,
  output ram_pkg::ram_addr_u wr_addr,
  output ram_pkg::data_t     wr_data
);
  import ram_pkg::*;
  import chan_pkg::*;

  logic [`FIFO_CHANNELS-1:0] req;
  logic [`FIFO_CHANNELS-1:0] gnt;
  ram_addr_u                 addr [`FIFO_CHANNELS];
  data_t                     data [`FIFO_CHANNELS];
  // Channel with first claim this cycle
  chan_t                     ptr;
  chan_t                     gnt_idx;

  //------------------------------------------------------------
  // Flatten the interface array
  //------------------------------------------------------------
  for (genvar g = 0; g < `FIFO_CHANNELS; g++) begin : g_port
    assign req[g]             = req_port[g].req;
    assign addr[g]            = req_port[g].addr;
    assign data[g]            = req_port[g].data;
    assign req_port[g].grant  = gnt[g];
  end

  //------------------------------------------------------------
  // Grant select
  //------------------------------------------------------------
  // Scan from the pointer, first requester wins
  always_comb begin : grant_sel
    int idx;
    gnt     = '0;
    gnt_idx = ptr;
    wr_en   = 1'b0;
    for (int i = 0; i < `FIFO_CHANNELS; i++) begin
      idx = (int'(ptr) + i) % `FIFO_CHANNELS;
      if (!wr_en && req[idx]) begin
        wr_en    = 1'b1;
        gnt[idx] = 1'b1;
        gnt_idx  = chan_t'(idx);
      end
    end
  end

  // Winner's address and data onto the port
  assign wr_addr = addr[gnt_idx];
  assign wr_data = data[gnt_idx];

  //------------------------------------------------------------
  // Priority pointer
  //------------------------------------------------------------
  // Move past the winner after each granted write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (wr_en) begin
      if (gnt_idx == chan_t'(`FIFO_CHANNELS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= gnt_idx + 1'b1;
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the dual FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dual_fifo -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dual_fifo)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

/* tb.f */
+incdir+hdl
+incdir+tests
hdl/chan_pkg.sv
hdl/ram_pkg.sv
hdl/fifo_ifs.sv
hdl/fifo_push_ctrl.sv
hdl/fifo_pop_ctrl.sv
hdl/wr_arbiter.sv
hdl/fifo_ram.sv
hdl/dual_fifo_top.sv
tests/tb_dual_fifo.sv

/* tests/tb_vectors.svh */
//------------------------------------------------------------
// Stimulus table of the dual FIFO testbench
// Per-row push and pop requests for both channels
//------------------------------------------------------------
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: test, push_valid[1:0], pop_ready[1:0], random data,
// data ch0, data ch1, hold cycles (bit 0 of each pair is channel 0)
localparam int NUM_VECS = 8;

localparam vec_t VECS [NUM_VECS] = '{
  // Bypass on both channels, then idle
  '{4'd1, 2'b11, 2'b11, 1'b0, 8'ha5, 8'h3c, 8'd1},
  '{4'd1, 2'b00, 2'b11, 1'b0, 8'h00, 8'h00, 8'd1},
  // Fill both channels, consumers stalled
  '{4'd2, 2'b11, 2'b00, 1'b1, 8'h00, 8'h00, 8'd12},
  // Drain both
  '{4'd3, 2'b00, 2'b11, 1'b0, 8'h00, 8'h00, 8'd6},
  // Ch0 streams through bypass, ch1 fills
  '{4'd4, 2'b11, 2'b01, 1'b1, 8'h00, 8'h00, 8'd8},
  // Ch0 fills, ch1 drains
  '{4'd4, 2'b01, 2'b10, 1'b1, 8'h00, 8'h00, 8'd6},
  // Push and pop together on both
  '{4'd4, 2'b11, 2'b11, 1'b1, 8'h00, 8'h00, 8'd8},
  '{4'd4, 2'b00, 2'b11, 1'b0, 8'h00, 8'h00, 8'd8}
};

`endif

/* tests/tb_dual_fifo.sv */
//------------------------------------------------------------
// Testbench of the two-channel shared-storage FIFO
// Table-driven stimulus against per-channel queue models
//------------------------------------------------------------
`timescale 1ns/1ns
`include "fifo_cfg.svh"

module tb_dual_fifo;
  import ram_pkg::*;
  import chan_pkg::*;

  typedef struct packed {
    logic [3:0]             test;
    logic [1:0]             pv;
    logic [1:0]             pr;
    logic                   rnd;
    logic [`FIFO_WIDTH-1:0] d0;
    logic [`FIFO_WIDTH-1:0] d1;
    logic [7:0]             hold;
  } vec_t;

  `include "tb_vectors.svh"

  localparam int NUM_TESTS = 5;
  localparam int N = `FIFO_CHANNELS;

  logic                      clk;
  logic                      rst_n;
  logic [N-1:0]              push_valid;
  logic [N-1:0]              push_ready;
  data_t                     push_data [N];
  logic [N-1:0]              pop_ready;
  logic [N-1:0]              pop_valid;
  data_t                     pop_data [N];
  count_t                    items [N];
  logic [N-1:0]              empty;

  // Entries the DUT should hold in each channel
  data_t model [N][$];
  // Expected arbiter priority
  int    ptr;
  int    errors;
  int    errors_at_start;
  int    tests_failed;
  string names [NUM_TESTS] = '{"reset", "bypass", "fill", "drain", "mixed"};

  dual_fifo_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .items      (items),
    .empty      (empty)
  );

  always #20 clk = ~clk;

  //------------------------------------------------------------
  // Checking
  //------------------------------------------------------------
  task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Compare one cycle against the model, then apply its handshakes
  task automatic check_cycle();
    logic [N-1:0] byp;
    logic [N-1:0] req;
    logic [N-1:0] gnt;
    int           win;
    int           idx;
    byp = '0;
    req = '0;
    gnt = '0;
    win = -1;
    for (int c = 0; c < N; c++) begin
      byp[c] = (model[c].size() == 0) && pop_ready[c];
      req[c] = push_valid[c] && (model[c].size() < `FIFO_DEPTH) && !byp[c];
    end
    // Round-robin from the expected pointer
    for (int i = 0; i < N; i++) begin
      idx = (ptr + i) % N;
      if (win < 0 && req[idx]) begin
        win = idx;
      end
    end
    if (win >= 0) begin
      gnt[win] = 1'b1;
      ptr = (win + 1) % N;
    end
    for (int c = 0; c < N; c++) begin
      compare($sformatf("items[%0d]", c), 32'(items[c]), 32'(model[c].size()));
      compare($sformatf("empty[%0d]", c), 32'(empty[c]), 32'(model[c].size() == 0));
      // A word headed for the RAM shows up one edge later
      compare($sformatf("pop_valid[%0d]", c), 32'(pop_valid[c]),
              32'(model[c].size() != 0 || (byp[c] && push_valid[c])));
      compare($sformatf("push_ready[%0d]", c), 32'(push_ready[c]), 32'(byp[c] || gnt[c]));
      if (pop_valid[c] && pop_ready[c]) begin
        // Head of the queue or the pushed word on bypass
        compare($sformatf("pop_data[%0d]", c), 32'(pop_data[c]),
                32'(model[c].size() != 0 ? model[c][0] : push_data[c]));
        if (model[c].size() != 0) begin
          void'(model[c].pop_front());
        end
      end
      if (push_valid[c] && push_ready[c] && !byp[c]) begin
        model[c].push_back(push_data[c]);
      end
    end
  endtask

  task automatic report_test(int t);
    int fails;
    fails = errors - errors_at_start;
    $display("test %-7s %s, %0d mismatches", names[t], (fails == 0) ? "ok" : "FAILED", fails);
    if (fails != 0) begin
      tests_failed++;
    end
    errors_at_start = errors;
  endtask

  //------------------------------------------------------------
  // Watchdog
  //------------------------------------------------------------
  initial begin : watchdog
    int limit;
    limit = 10 + 20;
    for (int r = 0; r < NUM_VECS; r++) begin
      limit += int'(VECS[r].hold);
    end
    #(limit * 40);
    $display("Watchdog expired after %0d cycles, stimulus did not finish", limit);
    $display("Test failed");
    $finish;
  end

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------
  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    push_valid      = '0;
    pop_ready       = '0;
    push_data       = '{default: '0};
    ptr             = 0;
    errors          = 0;
    errors_at_start = 0;
    tests_failed    = 0;
    void'($urandom(32'hd25a25c7));

    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;

    // Idle after reset
    @(negedge clk);
    for (int c = 0; c < N; c++) begin
      compare($sformatf("empty[%0d]", c), 32'(empty[c]), 32'd1);
      compare($sformatf("items[%0d]", c), 32'(items[c]), 32'd0);
      compare($sformatf("pop_valid[%0d]", c), 32'(pop_valid[c]), 32'd0);
    end
    report_test(0);

    for (int r = 0; r < NUM_VECS; r++) begin
      for (int h = 0; h < int'(VECS[r].hold); h++) begin
        @(posedge clk);
        #2;
        push_valid   = VECS[r].pv;
        pop_ready    = VECS[r].pr;
        push_data[0] = VECS[r].rnd ? data_t'($urandom) : VECS[r].d0;
        push_data[1] = VECS[r].rnd ? data_t'($urandom) : VECS[r].d1;
        @(negedge clk);
        check_cycle();
      end
      // Last row of a test
      if (r == NUM_VECS - 1 || VECS[r + 1].test != VECS[r].test) begin
        report_test(int'(VECS[r].test));
      end
    end

    @(posedge clk);
    #2;
    push_valid = '0;
    pop_ready  = '0;

    $display("summary: %0d tests, %0d failed, %0d mismatches", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
